// File: hdl/axi_wb_pkg.sv
package axi_wb_pkg;

   // bus geometry
   localparam int DATA_W   = 32;
   localparam int SEL_W    = DATA_W / 8;   // one select per byte lane
   localparam int ADDR_LSB = 2;            // byte offset inside a word

   typedef logic [DATA_W-1:0] data_t;
   typedef logic [SEL_W-1:0]  sel_t;
   typedef logic [1:0]        resp_t;

   // AXI response codes, only OKAY is ever returned
   localparam resp_t RESP_OKAY = 2'b00;

   // reads always fetch the whole word
   localparam sel_t SEL_ALL = '1;

endpackage

// File: hdl/wb_req_if.sv
// one bridge request, moved by valid/ready
interface wb_req_if #(
   parameter int AW = 32
);
   import axi_wb_pkg::*;

   logic                   valid;
   logic                   ready;
   logic [AW-ADDR_LSB-1:0] adr;   // word address
   data_t                  dat;   // write data, zero for reads
   sel_t                   sel;
   logic                   we;

   modport source (
      output valid, adr, dat, sel, we,
      input  ready
   );

   modport sink (
      input  valid, adr, dat, sel, we,
      output ready
   );

endinterface

// File: hdl/axi_req_capture.sv
module axi_req_capture #(
   parameter int AW = 32
) (
   input  logic                i_clk,
   input  logic                i_rst,

   input  logic [AW-1:0]       i_awaddr,
   input  logic                i_awvalid,
   output logic                o_awready,

   input  axi_wb_pkg::data_t   i_wdata,
   input  axi_wb_pkg::sel_t    i_wstrb,
   input  logic                i_wvalid,
   output logic                o_wready,

   input  logic [AW-1:0]       i_araddr,
   input  logic                i_arvalid,
   output logic                o_arready,

   wb_req_if.source            o_req
);
   import axi_wb_pkg::*;

   typedef enum logic [1:0] {
      s_idle,
      s_wait_w,   // address taken, write data still missing
      s_offer     // request held on o_req until the buffer takes it
   } state_t;

   state_t state;
   logic   take_aw;
   logic   take_w;
   logic   take_ar;

   // writes win over reads, nothing is taken while the buffer is full
   assign take_aw = (state == s_idle) && o_req.ready && i_awvalid;
   assign take_w  = o_req.ready && i_wvalid
                    && (((state == s_idle) && i_awvalid) || (state == s_wait_w));
   assign take_ar = (state == s_idle) && o_req.ready && !i_awvalid && i_arvalid;

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         state     <= s_idle;
         o_awready <= 1'b0;
         o_wready  <= 1'b0;
         o_arready <= 1'b0;
         o_req.valid <= 1'b0;
      end else begin
         // readies are single-cycle pulses
         o_awready <= take_aw;
         o_wready  <= take_w;
         o_arready <= take_ar;

         case (state)
            s_idle: begin
               if (take_w || take_ar) begin
                  o_req.valid <= 1'b1;
                  state       <= s_offer;
               end else if (take_aw) begin
                  state <= s_wait_w;
               end
            end
            s_wait_w: begin
               if (take_w) begin
                  o_req.valid <= 1'b1;
                  state       <= s_offer;
               end
            end
            s_offer: begin
               if (o_req.ready) begin
                  o_req.valid <= 1'b0;
                  state       <= s_idle;
               end
            end
            default: state <= s_idle;
         endcase
      end
   end

   // request fields
   always_ff @(posedge i_clk) begin
      if (take_aw) begin
         o_req.adr <= i_awaddr[AW-1:ADDR_LSB];
         o_req.we  <= 1'b1;
      end
      if (take_w) begin
         o_req.dat <= i_wdata;
         o_req.sel <= i_wstrb;
      end
      if (take_ar) begin
         o_req.adr <= i_araddr[AW-1:ADDR_LSB];
         o_req.we  <= 1'b0;
         o_req.dat <= '0;
         o_req.sel <= SEL_ALL;
      end
   end

   // each ready pulses once per accepted channel beat
   a_awready_pulse : assert property (@(posedge i_clk) disable iff (i_rst)
      o_awready |=> !o_awready);

   a_wready_pulse : assert property (@(posedge i_clk) disable iff (i_rst)
      o_wready |=> !o_wready);

   a_arready_pulse : assert property (@(posedge i_clk) disable iff (i_rst)
      o_arready |=> !o_arready);

   // the buffer may stall, the offered request must not change meanwhile
   a_req_stable : assert property (@(posedge i_clk) disable iff (i_rst)
      (o_req.valid && !o_req.ready) |=> (o_req.valid && $stable(o_req.adr)
         && $stable(o_req.dat) && $stable(o_req.sel) && $stable(o_req.we)));

endmodule

// File: hdl/req_fifo.sv
module req_fifo #(
   parameter int REQ_DEPTH = 4
) (
   input  logic      i_clk,
   input  logic      i_rst,
   wb_req_if.sink    i_wr,
   wb_req_if.source  o_rd
);
   import axi_wb_pkg::*;

   localparam int PTR_W = $clog2(REQ_DEPTH);
   localparam int ADR_W = i_wr.AW - ADDR_LSB;
   localparam logic [PTR_W:0] FULL_CNT = (PTR_W+1)'(REQ_DEPTH);

   logic [ADR_W-1:0] adr_mem [REQ_DEPTH];
   data_t            dat_mem [REQ_DEPTH];
   sel_t             sel_mem [REQ_DEPTH];
   logic             we_mem  [REQ_DEPTH];

   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [PTR_W:0]   count;   // one bit wider to tell full from empty
   logic             push;
   logic             pop;

   assign i_wr.ready = (count != FULL_CNT);
   assign push       = i_wr.valid && i_wr.ready;
   assign pop        = o_rd.valid && o_rd.ready;

   // oldest entry is always on the output
   assign o_rd.valid = (count != '0);
   assign o_rd.adr   = adr_mem[rd_ptr];
   assign o_rd.dat   = dat_mem[rd_ptr];
   assign o_rd.sel   = sel_mem[rd_ptr];
   assign o_rd.we    = we_mem[rd_ptr];

   always_ff @(posedge i_clk) begin
      if (push) begin
         adr_mem[wr_ptr] <= i_wr.adr;
         dat_mem[wr_ptr] <= i_wr.dat;
         sel_mem[wr_ptr] <= i_wr.sel;
         we_mem[wr_ptr]  <= i_wr.we;
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push)
            wr_ptr <= wr_ptr + 1'b1;   // wraps, depth is a power of two
         if (pop)
            rd_ptr <= rd_ptr + 1'b1;
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // equal pointers mean empty or full, the count tells which
   a_no_overflow : assert property (@(posedge i_clk) disable iff (i_rst)
      push |-> ((wr_ptr != rd_ptr) || (count == '0)));

   a_no_underflow : assert property (@(posedge i_clk) disable iff (i_rst)
      pop |-> ((wr_ptr != rd_ptr) || (count == FULL_CNT)));

endmodule

// File: hdl/wb_issue.sv
module wb_issue #(
   parameter int AW = 32
) (
   input  logic                                i_clk,
   input  logic                                i_rst,

   wb_req_if.sink                              i_req,

   output logic [AW-axi_wb_pkg::ADDR_LSB-1:0]  o_wb_adr,
   output axi_wb_pkg::data_t                   o_wb_dat,
   output axi_wb_pkg::sel_t                    o_wb_sel,
   output logic                                o_wb_we,
   output logic                                o_wb_stb,
   input  axi_wb_pkg::data_t                   i_wb_rdt,
   input  logic                                i_wb_ack,

   output logic                                o_bvalid,
   input  logic                                i_bready,

   output axi_wb_pkg::data_t                   o_rdata,
   output logic                                o_rvalid,
   input  logic                                i_rready
);
   import axi_wb_pkg::*;

   typedef enum logic [1:0] {
      s_idle,
      s_bus,    // classic cycle in progress, waiting for ack
      s_resp    // AXI response waiting to be taken
   } state_t;

   state_t state;
   logic   take;
   logic   resp_done;

   assign i_req.ready = (state == s_idle);
   assign take        = i_req.valid && i_req.ready;
   assign resp_done   = (o_bvalid && i_bready) || (o_rvalid && i_rready);

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         state    <= s_idle;
         o_wb_stb <= 1'b0;
         o_bvalid <= 1'b0;
         o_rvalid <= 1'b0;
      end else begin
         case (state)
            s_idle: begin
               if (take) begin
                  o_wb_stb <= 1'b1;
                  state    <= s_bus;
               end
            end
            s_bus: begin
               if (i_wb_ack) begin
                  o_wb_stb <= 1'b0;
                  o_bvalid <= o_wb_we;
                  o_rvalid <= !o_wb_we;
                  state    <= s_resp;
               end
            end
            s_resp: begin
               if (resp_done) begin
                  o_bvalid <= 1'b0;
                  o_rvalid <= 1'b0;
                  state    <= s_idle;
               end
            end
            default: state <= s_idle;
         endcase
      end
   end

   // bus fields and read data
   always_ff @(posedge i_clk) begin
      if (take) begin
         o_wb_adr <= i_req.adr;
         o_wb_dat <= i_req.dat;
         o_wb_sel <= i_req.sel;
         o_wb_we  <= i_req.we;
      end
      if (state == s_bus && i_wb_ack && !o_wb_we)
         o_rdata <= i_wb_rdt;
   end

   // a response stays offered until the master takes it
   a_b_hold : assert property (@(posedge i_clk) disable iff (i_rst)
      (o_bvalid && !i_bready) |=> o_bvalid);

   a_r_hold : assert property (@(posedge i_clk) disable iff (i_rst)
      (o_rvalid && !i_rready) |=> (o_rvalid && $stable(o_rdata)));

   // classic protocol, strobe and fields hold until the slave acks
   a_stb_hold : assert property (@(posedge i_clk) disable iff (i_rst)
      (o_wb_stb && !i_wb_ack) |=> (o_wb_stb && $stable(o_wb_adr)
         && $stable(o_wb_dat) && $stable(o_wb_sel) && $stable(o_wb_we)));

endmodule

// File: hdl/axi_wb_bridge.sv
module axi_wb_bridge #(
   parameter int AW        = 32,
   parameter int REQ_DEPTH = 4
) (
   input  logic                                i_clk,
   input  logic                                i_rst,

   // AXI4-Lite slave
   input  logic [AW-1:0]                       i_awaddr,
   input  logic                                i_awvalid,
   output logic                                o_awready,
   input  axi_wb_pkg::data_t                   i_wdata,
   input  axi_wb_pkg::sel_t                    i_wstrb,
   input  logic                                i_wvalid,
   output logic                                o_wready,
   output axi_wb_pkg::resp_t                   o_bresp,
   output logic                                o_bvalid,
   input  logic                                i_bready,
   input  logic [AW-1:0]                       i_araddr,
   input  logic                                i_arvalid,
   output logic                                o_arready,
   output axi_wb_pkg::data_t                   o_rdata,
   output axi_wb_pkg::resp_t                   o_rresp,
   output logic                                o_rvalid,
   input  logic                                i_rready,

   // Wishbone classic master
   output logic [AW-axi_wb_pkg::ADDR_LSB-1:0]  o_wb_adr,
   output axi_wb_pkg::data_t                   o_wb_dat,
   output axi_wb_pkg::sel_t                    o_wb_sel,
   output logic                                o_wb_we,
   output logic                                o_wb_stb,
   input  axi_wb_pkg::data_t                   i_wb_rdt,
   input  logic                                i_wb_ack
);
   import axi_wb_pkg::*;

   wb_req_if #(.AW(AW)) cap_bus ();   // capture to buffer
   wb_req_if #(.AW(AW)) iss_bus ();   // buffer to Wishbone side

   // no error path, every access completes OKAY
   assign o_bresp = RESP_OKAY;
   assign o_rresp = RESP_OKAY;

   axi_req_capture #(.AW(AW)) i_capture (
      .i_clk     (i_clk),
      .i_rst     (i_rst),
      .i_awaddr  (i_awaddr),
      .i_awvalid (i_awvalid),
      .o_awready (o_awready),
      .i_wdata   (i_wdata),
      .i_wstrb   (i_wstrb),
      .i_wvalid  (i_wvalid),
      .o_wready  (o_wready),
      .i_araddr  (i_araddr),
      .i_arvalid (i_arvalid),
      .o_arready (o_arready),
      .o_req     (cap_bus)
   );

   req_fifo #(.REQ_DEPTH(REQ_DEPTH)) i_fifo (
      .i_clk (i_clk),
      .i_rst (i_rst),
      .i_wr  (cap_bus),
      .o_rd  (iss_bus)
   );

   wb_issue #(.AW(AW)) i_issue (
      .i_clk    (i_clk),
      .i_rst    (i_rst),
      .i_req    (iss_bus),
      .o_wb_adr (o_wb_adr),
      .o_wb_dat (o_wb_dat),
      .o_wb_sel (o_wb_sel),
      .o_wb_we  (o_wb_we),
      .o_wb_stb (o_wb_stb),
      .i_wb_rdt (i_wb_rdt),
      .i_wb_ack (i_wb_ack),
      .o_bvalid (o_bvalid),
      .i_bready (i_bready),
      .o_rdata  (o_rdata),
      .o_rvalid (o_rvalid),
      .i_rready (i_rready)
   );

endmodule

// File: bench/wb_mem_model.sv
module wb_mem_model #(
   parameter int AW = 32
) (
   input  logic                                i_clk,
   input  logic                                i_rst,
   input  logic [AW-axi_wb_pkg::ADDR_LSB-1:0]  i_wb_adr,
   input  axi_wb_pkg::data_t                   i_wb_dat,
   input  axi_wb_pkg::sel_t                    i_wb_sel,
   input  logic                                i_wb_we,
   input  logic                                i_wb_stb,
   output axi_wb_pkg::data_t                   o_wb_rdt,
   output logic                                o_wb_ack
);
   timeunit 1ns;
   timeprecision 100ps;
   import axi_wb_pkg::*;

   data_t    mem [256];
   int       seed = 23002;
   int       wait_left;
   logic     armed;   // wait count drawn for the current cycle
   logic [7:0] idx;

   assign idx = i_wb_adr[7:0];

   initial begin
      for (int i = 0; i < 256; i++)
         mem[i] = {8'(i), 8'(255 - i), 8'(i * 3), 8'h5a};
   end

   always @(posedge i_clk) begin
      int waits;
      if (i_rst) begin
         o_wb_ack <= 1'b0;
         armed    <= 1'b0;
      end else begin
         o_wb_ack <= 1'b0;
         if (i_wb_stb && !o_wb_ack) begin
            if (!armed) begin
               waits = $unsigned($random(seed)) % 4;
               wait_left <= waits;
               armed     <= (waits != 0);
            end
            if ((!armed && waits == 0) || (armed && wait_left == 1)) begin
               armed    <= 1'b0;
               o_wb_ack <= 1'b1;
               // lanes left out of the select read as zero
               for (int b = 0; b < SEL_W; b++)
                  o_wb_rdt[8*b +: 8] <= i_wb_sel[b] ? mem[idx][8*b +: 8] : 8'h00;
               if (i_wb_we) begin
                  for (int b = 0; b < SEL_W; b++)
                     if (i_wb_sel[b])
                        mem[idx][8*b +: 8] <= i_wb_dat[8*b +: 8];
               end
            end else if (armed) begin
               wait_left <= wait_left - 1;
            end
         end
      end
   end

endmodule

// File: bench/tb_axi_wb_bridge.sv
module tb_axi_wb_bridge;
   timeunit 1ns;
   timeprecision 100ps;
   import axi_wb_pkg::*;

   localparam int AW        = 32;
   localparam int REQ_DEPTH = 4;
   localparam int N_TXN     = 70;
   localparam int LIMIT_NS  = (N_TXN * 20 + 200) * 8;

   logic clk = 1'b0;
   logic rst;
   logic [AW-1:0] awaddr, araddr;
   logic awvalid, wvalid, arvalid, bready, rready;
   data_t wdata;
   sel_t  wstrb;
   logic awready, wready, arready, bvalid, rvalid;
   resp_t bresp, rresp;
   data_t rdata;
   logic [AW-ADDR_LSB-1:0] wb_adr;
   data_t wb_dat, wb_rdt;
   sel_t  wb_sel;
   logic  wb_we, wb_stb, wb_ack;

   data_t shadow [256];      // expected memory contents
   logic  exp_we [$];        // expected responses in issue order
   data_t exp_data [$];
   int    seed = 23002;
   int    accepted = 0;
   int    responded = 0;
   logic  hold_low = 1'b0;   // stall both response channels
   logic  rand_ready = 1'b0;
   logic  prev_b, prev_bready, prev_r, prev_rready;
   logic  got_we;
   data_t got_exp;
   logic  race_write_done;   // set once the racing write is accepted

   always #4 clk = ~clk;

   axi_wb_bridge #(.AW(AW), .REQ_DEPTH(REQ_DEPTH)) i_dut (
      .i_clk(clk), .i_rst(rst),
      .i_awaddr(awaddr), .i_awvalid(awvalid), .o_awready(awready),
      .i_wdata(wdata), .i_wstrb(wstrb), .i_wvalid(wvalid), .o_wready(wready),
      .o_bresp(bresp), .o_bvalid(bvalid), .i_bready(bready),
      .i_araddr(araddr), .i_arvalid(arvalid), .o_arready(arready),
      .o_rdata(rdata), .o_rresp(rresp), .o_rvalid(rvalid), .i_rready(rready),
      .o_wb_adr(wb_adr), .o_wb_dat(wb_dat), .o_wb_sel(wb_sel), .o_wb_we(wb_we),
      .o_wb_stb(wb_stb), .i_wb_rdt(wb_rdt), .i_wb_ack(wb_ack)
   );

   wb_mem_model #(.AW(AW)) i_mem (
      .i_clk(clk), .i_rst(rst), .i_wb_adr(wb_adr), .i_wb_dat(wb_dat),
      .i_wb_sel(wb_sel), .i_wb_we(wb_we), .i_wb_stb(wb_stb),
      .o_wb_rdt(wb_rdt), .o_wb_ack(wb_ack)
   );

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("Finished with errors");
      $fatal(1, "run stopped at %0t", $time);
   endtask

   task automatic check_data(input string name, input data_t got, input data_t exp);
      if (got !== exp)
         fail_run($sformatf("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp));
   endtask

   task automatic check_resp(input string name, input resp_t got, input resp_t exp);
      if (got !== exp)
         fail_run($sformatf("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp));
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp)
         fail_run($sformatf("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp));
   endtask

   // same rule as the memory model's power-up contents
   function automatic data_t fill_word(input int i);
      return {8'(i), 8'(255 - i), 8'(i * 3), 8'h5a};
   endfunction

   function automatic data_t merge_bytes(input data_t old, input data_t nw, input sel_t strb);
      data_t r;
      r = old;
      for (int b = 0; b < SEL_W; b++)
         if (strb[b])
            r[8*b +: 8] = nw[8*b +: 8];
      return r;
   endfunction

   function automatic data_t ref_read(input int idx);
      return shadow[idx];
   endfunction

   function automatic logic [AW-1:0] byte_addr(input int idx);
      logic [AW-1:0] a;
      a = '0;
      a[ADDR_LSB +: 8] = 8'(idx);
      return a;
   endfunction

   task automatic axi_write(input int idx, input data_t data, input sel_t strb,
                            input int aw_lead);
      logic aw_done;
      logic w_done;
      aw_done = 1'b0;
      w_done  = 1'b0;
      @(posedge clk);
      awaddr  <= byte_addr(idx);
      awvalid <= 1'b1;
      for (int c = 0; c < aw_lead; c++) begin
         @(posedge clk);
         if (wready)
            fail_run("o_wready rose before any write data was offered");
         if (!aw_done && awready) begin
            awvalid <= 1'b0;
            aw_done = 1'b1;
         end
      end
      if (aw_lead > 0 && !aw_done)
         fail_run("write address was not accepted ahead of its data");
      wdata  <= data;
      wstrb  <= strb;
      wvalid <= 1'b1;
      while (!(aw_done && w_done)) begin
         @(posedge clk);
         if (!aw_done && awready) begin
            awvalid <= 1'b0;
            aw_done = 1'b1;
         end
         if (!w_done && wready) begin
            wvalid <= 1'b0;
            w_done = 1'b1;
         end
      end
      shadow[idx] = merge_bytes(shadow[idx], data, strb);
      exp_we.push_back(1'b1);
      exp_data.push_back('0);
      accepted++;
   endtask

   task automatic axi_read(input int idx);
      @(posedge clk);
      araddr  <= byte_addr(idx);
      arvalid <= 1'b1;
      do
         @(posedge clk);
      while (!arready);
      arvalid <= 1'b0;
      exp_we.push_back(1'b0);
      exp_data.push_back(ref_read(idx));
      accepted++;
   endtask

   task automatic random_requests(input int n);
      int idx;
      for (int i = 0; i < n; i++) begin
         idx = $unsigned($random(seed)) % 16;
         if ($random(seed) & 1)
            axi_write(idx, data_t'($random(seed)), sel_t'($random(seed)), 0);
         else
            axi_read(idx);
      end
   endtask

   // response channel readiness
   always @(posedge clk) begin
      if (hold_low) begin
         bready <= 1'b0;
         rready <= 1'b0;
      end else if (rand_ready) begin
         bready <= ($random(seed) & 3) != 0;
         rready <= ($random(seed) & 3) != 0;
      end else begin
         bready <= 1'b1;
         rready <= 1'b1;
      end
   end

   // compares every B and R beat against the expected queue
   always @(posedge clk) begin
      if (!rst) begin
         if (prev_b && !prev_bready && !bvalid)
            fail_run("o_bvalid dropped before the response was taken");
         if (prev_r && !prev_rready && !rvalid)
            fail_run("o_rvalid dropped before the response was taken");
         if ((bvalid && bready) || (rvalid && rready)) begin
            if (exp_we.size() == 0)
               fail_run("response arrived with no request outstanding");
            got_we  = exp_we.pop_front();
            got_exp = exp_data.pop_front();
            responded++;
            if (bvalid) begin
               if (!got_we)
                  fail_run("write response came where a read was expected");
               check_resp("o_bresp", bresp, RESP_OKAY);
            end else begin
               if (got_we)
                  fail_run("read data came where a write response was expected");
               check_data("o_rdata", rdata, got_exp);
               check_resp("o_rresp", rresp, RESP_OKAY);
            end
         end
         // buffer entries plus the one held by the Wishbone side
         if (accepted - responded > REQ_DEPTH + 1)
            fail_run("more requests accepted than the bridge can hold");
      end
      prev_b      <= bvalid;
      prev_bready <= bready;
      prev_r      <= rvalid;
      prev_rready <= rready;
   end

   initial begin
      #(LIMIT_NS);
      $display("watchdog expired, the bridge stopped making progress");
      $display("Finished with errors");
      $fatal(1, "timeout");
   end

   initial begin
      for (int i = 0; i < 256; i++)
         shadow[i] = fill_word(i);
      rst <= 1'b1;
      awaddr <= '0;
      awvalid <= 1'b0;
      wdata <= '0;
      wstrb <= '0;
      wvalid <= 1'b0;
      araddr <= '0;
      arvalid <= 1'b0;
      bready <= 1'b1;
      rready <= 1'b1;
      repeat (2) @(posedge clk);
      rst <= 1'b0;
      @(posedge clk);
      @(posedge clk);
      check_flag("o_awready", awready, 1'b0);
      check_flag("o_wready", wready, 1'b0);
      check_flag("o_arready", arready, 1'b0);
      check_flag("o_bvalid", bvalid, 1'b0);
      check_flag("o_rvalid", rvalid, 1'b0);
      check_flag("o_wb_stb", wb_stb, 1'b0);

      axi_write(3, 32'hdead_beef, 4'hf, 0);   // full word then read back
      axi_read(3);
      axi_write(5, 32'h1122_3344, 4'hf, 0);   // partial strobe merge
      axi_write(5, 32'haabb_ccdd, 4'b0101, 0);
      axi_read(5);
      axi_write(7, 32'h0bad_f00d, 4'hf, 5);   // address well before data
      axi_read(7);

      // fill the bridge with both response channels stalled
      hold_low <= 1'b1;
      fork
         random_requests(10);
         begin
            repeat (60) @(posedge clk);
            if (accepted - responded != REQ_DEPTH + 1)
               fail_run("AXI readies did not stop at a full buffer");
            hold_low   <= 1'b0;
            rand_ready <= 1'b1;
         end
      join
      random_requests(50);
      while (exp_we.size() != 0)
         @(posedge clk);
      rand_ready <= 1'b0;

      // write and read on one address in the same cycle
      race_write_done = 1'b0;
      fork
         begin
            axi_write(9, 32'h5555_aaaa, 4'hf, 0);
            race_write_done = 1'b1;
         end
         begin
            axi_read(9);
            if (!race_write_done)
               fail_run("read was accepted ahead of the write raised with it");
         end
      join
      while (exp_we.size() != 0)
         @(posedge clk);
      repeat (4) @(posedge clk);
      $display("Finished with no errors");
      $finish;
   end

endmodule

// File: axi_wb_bridge.f
hdl/axi_wb_pkg.sv
hdl/wb_req_if.sv
hdl/axi_req_capture.sv
hdl/req_fifo.sv
hdl/wb_issue.sv
hdl/axi_wb_bridge.sv
bench/wb_mem_model.sv
bench/tb_axi_wb_bridge.sv

// File: run_sim.sh
#!/bin/sh
# compile the bridge and its testbench with Verilator, then run the model

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_axi_wb_bridge \
   -f axi_wb_bridge.f \
   -Mdir obj_dir -o sim_tb
status=$?
if [ $status -ne 0 ]; then
   echo "compile failed with status $status"
   exit $status
fi

./obj_dir/sim_tb
status=$?
if [ $status -ne 0 ]; then
   echo "simulation failed with status $status"
   exit $status
fi

exit 0
